/* hdl/rv32_isa_pkg.sv */
// RV32I encoding constants and opcode enum, imported by the decoders and the testbench
package rv32_isa_pkg;

    // Instruction field widths
    localparam int inst_w     = 32;
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;

    // Field positions inside the instruction word
    localparam int opcode_lsb = 0;   // inst[6:0]
    localparam int funct3_lsb = 12;  // inst[14:12]
    localparam int funct7_lsb = 25;  // inst[31:25]

    // Major opcodes handled by the decode stage
    typedef enum logic [opcode_w-1:0] {
        OPC_OP     = 7'b0110011,  // R-type ALU
        OPC_OP_IMM = 7'b0010011,  // Immediate ALU
        OPC_LOAD   = 7'b0000011,  // LB/LH/LW/LBU/LHU
        OPC_STORE  = 7'b0100011,  // SB/SH/SW
        OPC_BRANCH = 7'b1100011,  // Conditional branches
        OPC_JAL    = 7'b1101111,  // Jump and link
        OPC_JALR   = 7'b1100111,  // Jump and link register
        OPC_AUIPC  = 7'b0010111,  // Add upper imm to PC
        OPC_SYSTEM = 7'b1110011   // Ebreak lives here, rest not decoded
    } opcode_t;

    // Funct7 selectors for ADD/SUB, SRL/SRA, SRLI/SRAI
    localparam logic [funct7_w-1:0] funct7_base = 7'b0000000;
    localparam logic [funct7_w-1:0] funct7_alt  = 7'b0100000;

    // Full ebreak word, matched bit for bit
    localparam logic [inst_w-1:0] inst_ebreak = 32'h0010_0073;

    // Branch condition codes in funct3
    localparam logic [funct3_w-1:0] F3_BEQ  = 3'b000;  // rs1 == rs2
    localparam logic [funct3_w-1:0] F3_BNE  = 3'b001;  // rs1 != rs2
    localparam logic [funct3_w-1:0] F3_BLT  = 3'b100;  // Signed less
    localparam logic [funct3_w-1:0] F3_BGE  = 3'b101;  // Signed greater or equal
    localparam logic [funct3_w-1:0] F3_BLTU = 3'b110;  // Unsigned less
    localparam logic [funct3_w-1:0] F3_BGEU = 3'b111;  // Unsigned greater or equal

endpackage

/* hdl/ctrl_pkg.sv */
// Control-word enums and widths of the decode outputs, shared by the RTL and the testbench
package ctrl_pkg;

    // Field widths of the control word
    localparam int alu_op_w     = 5;
    localparam int op1_sel_w    = 2;
    localparam int op2_sel_w    = 2;
    localparam int pc_sel_w     = 3;
    localparam int wb_sel_w     = 2;
    localparam int mem_access_w = 3;  // Same coding as load/store funct3

    typedef enum logic [alu_op_w-1:0] {
        ALU_ADD  = 5'd0,  // Also the nop value
        ALU_SUB  = 5'd1,
        ALU_SLT  = 5'd2,
        ALU_SLTU = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_OR   = 5'd5,
        ALU_AND  = 5'd6,
        ALU_SLL  = 5'd7,
        ALU_SRL  = 5'd8,
        ALU_SRA  = 5'd9
    } alu_op_t;

    typedef enum logic [op1_sel_w-1:0] {
        OP1_RS1 = 2'b00,  // Register rs1
        OP1_PC  = 2'b01   // Current PC, AUIPC
    } op1_sel_t;

    typedef enum logic [op2_sel_w-1:0] {
        OP2_UJ_IMM = 2'b00,  // U/J immediate
        OP2_I_IMM  = 2'b01,  // I immediate
        OP2_S_IMM  = 2'b10,  // S immediate
        OP2_RS2    = 2'b11   // Register rs2
    } op2_sel_t;

    typedef enum logic [pc_sel_w-1:0] {
        PC_SEQ    = 3'b000,  // PC + 4
        PC_JALR   = 3'b001,  // rs1 + imm
        PC_BRANCH = 3'b010,  // Taken branch target
        PC_JAL    = 3'b011   // Jump target
    } pc_sel_t;

    typedef enum logic [wb_sel_w-1:0] {
        WB_NONE = 2'b00,  // No write-back
        WB_PC4  = 2'b01,  // Link address
        WB_ALU  = 2'b10,  // ALU result
        WB_MEM  = 2'b11   // Load data
    } wb_sel_t;

    localparam logic [mem_access_w-1:0] mem_access_none = 3'b000;  // Non-memory instructions

endpackage

/* hdl/ctrl_table.sv */
// Decode table, maps an instruction to its base control word and the ebreak flag
`timescale 1ns/1ps

module ctrl_table
    import rv32_isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic [inst_w-1:0]       inst,          // Instruction under decode
    output alu_op_t                 alu_op,        // ALU operation
    output op1_sel_t                op1_sel,       // Operand 1 source
    output op2_sel_t                op2_sel,       // Operand 2 source
    output pc_sel_t                 table_pc_sel,  // Next-PC select before branch resolution
    output logic                    rf_we,         // Register file write
    output logic                    mem_en,        // Data memory access
    output logic                    mem_wen,       // Data memory write
    output wb_sel_t                 wb_sel,        // Write-back source
    output logic [mem_access_w-1:0] mem_access,    // Access width for loads/stores
    output logic                    is_ebreak      // Exact ebreak match
);

    opcode_t             opcode;
    logic [funct3_w-1:0] funct3;
    logic [funct7_w-1:0] funct7;
    logic                f7_base;  // funct7 is 0000000
    logic                f7_alt;   // funct7 is 0100000

    // ALU op from funct3, alt picks SUB/SRA
    function automatic alu_op_t alu_from_f3(input logic [funct3_w-1:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;  // 3'b111
        endcase
        return op;
    endfunction

    assign opcode  = opcode_t'(inst[opcode_lsb +: opcode_w]);
    assign funct3  = inst[funct3_lsb +: funct3_w];
    assign funct7  = inst[funct7_lsb +: funct7_w];
    assign f7_base = (funct7 == funct7_base);
    assign f7_alt  = (funct7 == funct7_alt);

    always_comb begin
        alu_op       = ALU_ADD;  // Nop word, kept for unmatched encodings
        op1_sel      = OP1_RS1;
        op2_sel      = OP2_UJ_IMM;
        table_pc_sel = PC_SEQ;
        rf_we        = 1'b0;
        mem_en       = 1'b0;
        mem_wen      = 1'b0;
        wb_sel       = WB_NONE;
        mem_access   = mem_access_none;

        case (opcode)
            OPC_OP: begin
                // Alt funct7 only legal for ADD/SUB and SRL/SRA
                if (f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    alu_op  = alu_from_f3(funct3, f7_alt);
                    op2_sel = OP2_RS2;
                    rf_we   = 1'b1;
                    wb_sel  = WB_ALU;
                end
            end
            OPC_OP_IMM: begin
                if (funct3 != 3'b101 || f7_base || f7_alt) begin  // Shift-right needs a known funct7
                    alu_op  = alu_from_f3(funct3, f7_alt && (funct3 == 3'b101));  // ADDI has no SUB
                    op2_sel = OP2_I_IMM;
                    rf_we   = 1'b1;
                    wb_sel  = WB_ALU;
                end
            end
            OPC_LOAD: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    op2_sel    = OP2_I_IMM;  // Address is rs1 + imm
                    rf_we      = 1'b1;
                    mem_en     = 1'b1;
                    wb_sel     = WB_MEM;
                    mem_access = funct3;     // Width and sign from funct3
                end
            end
            OPC_STORE: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010}) begin  // SB/SH/SW
                    op2_sel    = OP2_S_IMM;
                    mem_en     = 1'b1;
                    mem_wen    = 1'b1;
                    mem_access = funct3;
                end
            end
            OPC_BRANCH: begin
                if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
                    op2_sel = OP2_RS2;  // Comparator sees rs2
                    wb_sel  = WB_ALU;   // Target resolved later in ctrl_register
                end
            end
            OPC_JAL: begin
                op2_sel      = OP2_UJ_IMM;
                table_pc_sel = PC_JAL;
                rf_we        = 1'b1;
                wb_sel       = WB_PC4;  // Link register gets PC + 4
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    op2_sel      = OP2_I_IMM;
                    table_pc_sel = PC_JALR;
                    rf_we        = 1'b1;
                    wb_sel       = WB_PC4;
                end
            end
            OPC_AUIPC: begin
                op1_sel = OP1_PC;
                op2_sel = OP2_UJ_IMM;
                rf_we   = 1'b1;
                wb_sel  = WB_ALU;
            end
            default: begin
                // SYSTEM and unknown opcodes keep the nop word
            end
        endcase
    end

    assign is_ebreak = (inst == inst_ebreak);  // Whole word, not just opcode

endmodule

/* hdl/branch_resolver.sv */
// Branch resolver, flags conditional branches and decides taken from the comparator flags
`timescale 1ns/1ps

module branch_resolver
    import rv32_isa_pkg::*;
(
    input  logic [inst_w-1:0] inst,       // Instruction under decode
    input  logic              br_eq,      // rs1 == rs2
    input  logic              br_lt,      // rs1 < rs2 signed
    input  logic              br_ltu,     // rs1 < rs2 unsigned
    output logic              is_branch,  // Valid conditional branch
    output logic              br_taken    // Condition holds
);

    opcode_t             opcode;
    logic [funct3_w-1:0] funct3;
    logic                cond;  // Selected condition, before qualifying

    assign opcode = opcode_t'(inst[opcode_lsb +: opcode_w]);
    assign funct3 = inst[funct3_lsb +: funct3_w];

    always_comb begin
        is_branch = (opcode == OPC_BRANCH);
        case (funct3)
            F3_BEQ:  cond = br_eq;
            F3_BNE:  cond = !br_eq;
            F3_BLT:  cond = br_lt;
            F3_BGE:  cond = !br_lt;
            F3_BLTU: cond = br_ltu;
            F3_BGEU: cond = !br_ltu;
            default: begin
                cond      = 1'b0;
                is_branch = 1'b0;  // 010/011 are not branches
            end
        endcase
    end

    assign br_taken = is_branch && cond;  // Never taken for non-branches

endmodule

/* hdl/ctrl_register.sv */
// Output register of decode, merges table and branch result into the execute-stage controls
`timescale 1ns/1ps

module ctrl_register
    import ctrl_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,               // Sync, active high
    input  alu_op_t                 table_alu_op,      // Base word from ctrl_table
    input  op1_sel_t                table_op1_sel,
    input  op2_sel_t                table_op2_sel,
    input  pc_sel_t                 table_pc_sel,
    input  logic                    table_rf_we,
    input  logic                    table_mem_en,
    input  logic                    table_mem_wen,
    input  wb_sel_t                 table_wb_sel,
    input  logic [mem_access_w-1:0] table_mem_access,
    input  logic                    table_is_ebreak,
    input  logic                    is_branch,         // From branch_resolver
    input  logic                    br_taken,
    output alu_op_t                 alu_op,            // Registered controls to execute
    output op1_sel_t                op1_sel,
    output op2_sel_t                op2_sel,
    output pc_sel_t                 pc_sel,
    output logic                    rf_we,
    output logic                    mem_en,
    output logic                    mem_wen,
    output wb_sel_t                 wb_sel,
    output logic [mem_access_w-1:0] mem_access,
    output logic                    is_ebreak
);

    pc_sel_t pc_sel_next;  // Final next-PC select

    always_comb begin
        if (is_branch) begin
            pc_sel_next = br_taken ? PC_BRANCH : PC_SEQ;
        end else begin
            pc_sel_next = table_pc_sel;  // Jumps and sequential
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_op     <= ALU_ADD;  // Safe nop
            op1_sel    <= OP1_RS1;
            op2_sel    <= OP2_UJ_IMM;
            pc_sel     <= PC_SEQ;
            rf_we      <= 1'b0;
            mem_en     <= 1'b0;
            mem_wen    <= 1'b0;
            wb_sel     <= WB_NONE;
            mem_access <= mem_access_none;
            is_ebreak  <= 1'b0;
        end else begin
            alu_op     <= table_alu_op;
            op1_sel    <= table_op1_sel;
            op2_sel    <= table_op2_sel;
            pc_sel     <= pc_sel_next;
            rf_we      <= table_rf_we;
            mem_en     <= table_mem_en;
            mem_wen    <= table_mem_wen;
            wb_sel     <= table_wb_sel;
            mem_access <= table_mem_access;
            is_ebreak  <= table_is_ebreak;
        end
    end

endmodule

/* hdl/decode_stage.sv */
// Decode stage top, one-cycle decode of an RV32I instruction into registered controls
`timescale 1ns/1ps

module decode_stage
    import rv32_isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [inst_w-1:0]       inst,        // New instruction every cycle
    input  logic                    br_eq,       // Comparator flags for inst
    input  logic                    br_lt,
    input  logic                    br_ltu,
    output alu_op_t                 alu_op,      // Controls, one cycle after inst
    output op1_sel_t                op1_sel,
    output op2_sel_t                op2_sel,
    output pc_sel_t                 pc_sel,
    output logic                    rf_we,
    output logic                    mem_en,
    output logic                    mem_wen,
    output wb_sel_t                 wb_sel,
    output logic [mem_access_w-1:0] mem_access,
    output logic                    is_ebreak
);

    alu_op_t                 table_alu_op;      // Base control word
    op1_sel_t                table_op1_sel;
    op2_sel_t                table_op2_sel;
    pc_sel_t                 table_pc_sel;
    logic                    table_rf_we;
    logic                    table_mem_en;
    logic                    table_mem_wen;
    wb_sel_t                 table_wb_sel;
    logic [mem_access_w-1:0] table_mem_access;
    logic                    table_is_ebreak;
    logic                    is_branch;         // Resolver results
    logic                    br_taken;

    ctrl_table i_ctrl_table (
        .inst         (inst),
        .alu_op       (table_alu_op),
        .op1_sel      (table_op1_sel),
        .op2_sel      (table_op2_sel),
        .table_pc_sel (table_pc_sel),
        .rf_we        (table_rf_we),
        .mem_en       (table_mem_en),
        .mem_wen      (table_mem_wen),
        .wb_sel       (table_wb_sel),
        .mem_access   (table_mem_access),
        .is_ebreak    (table_is_ebreak)
    );

    branch_resolver i_branch_resolver (
        .inst      (inst),
        .br_eq     (br_eq),
        .br_lt     (br_lt),
        .br_ltu    (br_ltu),
        .is_branch (is_branch),
        .br_taken  (br_taken)
    );

    ctrl_register i_ctrl_register (
        .clk              (clk),
        .rst              (rst),
        .table_alu_op     (table_alu_op),
        .table_op1_sel    (table_op1_sel),
        .table_op2_sel    (table_op2_sel),
        .table_pc_sel     (table_pc_sel),
        .table_rf_we      (table_rf_we),
        .table_mem_en     (table_mem_en),
        .table_mem_wen    (table_mem_wen),
        .table_wb_sel     (table_wb_sel),
        .table_mem_access (table_mem_access),
        .table_is_ebreak  (table_is_ebreak),
        .is_branch        (is_branch),
        .br_taken         (br_taken),
        .alu_op           (alu_op),
        .op1_sel          (op1_sel),
        .op2_sel          (op2_sel),
        .pc_sel           (pc_sel),
        .rf_we            (rf_we),
        .mem_en           (mem_en),
        .mem_wen          (mem_wen),
        .wb_sel           (wb_sel),
        .mem_access       (mem_access),
        .is_ebreak        (is_ebreak)
    );

endmodule

/* testbench/tb_decode_stage.sv */
// Self-checking testbench for decode_stage, runs random RV32I words against a reference model
`timescale 1ns/1ps

module tb_decode_stage
    import rv32_isa_pkg::*;
    import ctrl_pkg::*;
();

    typedef struct packed {
        alu_op_t                 alu_op;
        op1_sel_t                op1_sel;
        op2_sel_t                op2_sel;
        pc_sel_t                 pc_sel;
        logic                    rf_we;
        logic                    mem_en;
        logic                    mem_wen;
        wb_sel_t                 wb_sel;
        logic [mem_access_w-1:0] mem_access;
        logic                    is_ebreak;
    } ctrl_t;

    localparam int      timeout_cycles = 2000;  // About 500 stimulus cycles plus margin
    localparam ctrl_t   nop_c = '{ALU_ADD, OP1_RS1, OP2_UJ_IMM, PC_SEQ, 1'b0, 1'b0, 1'b0,
                                  WB_NONE, 3'b000, 1'b0};
    localparam alu_op_t base_alu [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                         ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};  // By funct3
    // SUB, JAL, SW, EBREAK, each decodes to a non-nop word
    localparam logic [31:0] reset_words [4] = '{32'h4000_0033, 32'h0000_006f,
                                                32'h0000_2023, inst_ebreak};

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic        br_eq;
    logic        br_lt;
    logic        br_ltu;
    alu_op_t     alu_op;
    op1_sel_t    op1_sel;
    op2_sel_t    op2_sel;
    pc_sel_t     pc_sel;
    logic        rf_we;
    logic        mem_en;
    logic        mem_wen;
    wb_sel_t     wb_sel;
    logic [2:0]  mem_access;
    logic        is_ebreak;

    ctrl_t exp_ctrl;           // Expected controls for the word seen at the last edge
    logic  chk_en = 1'b0;      // Outputs defined only after the first edge
    int    phase = 0;          // Behavior being driven
    int    exp_phase = 0;
    int    err_cnt [10] = '{default: 0};
    string out_name [10] = '{"alu_op", "op1_sel", "op2_sel", "pc_sel", "rf_we", "mem_en",
                             "mem_wen", "wb_sel", "mem_access", "is_ebreak"};
    string phase_name [6] = '{"reset", "alu decode", "memory decode", "branch resolution",
                              "jump/auipc/ebreak", "unmatched"};

    decode_stage i_decode_stage (
        .clk(clk), .rst(rst), .inst(inst), .br_eq(br_eq), .br_lt(br_lt), .br_ltu(br_ltu),
        .alu_op(alu_op), .op1_sel(op1_sel), .op2_sel(op2_sel), .pc_sel(pc_sel),
        .rf_we(rf_we), .mem_en(mem_en), .mem_wen(mem_wen), .wb_sel(wb_sel),
        .mem_access(mem_access), .is_ebreak(is_ebreak)
    );

    // Expected controls straight from the decode rules
    function automatic ctrl_t decode_model(input logic [31:0] w, input logic eq,
                                           input logic lt, input logic ltu);
        ctrl_t      c;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       taken;
        f3 = w[14:12];
        f7 = w[31:25];
        c = nop_c;
        c.is_ebreak = (w == 32'h0010_0073);  // Whole word only
        case (w[6:0])
            OPC_OP: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    c.alu_op = base_alu[f3];
                    if (f7 == 7'h20) c.alu_op = (f3 == 3'd0) ? ALU_SUB : ALU_SRA;
                    c.op2_sel = OP2_RS2;
                    c.rf_we   = 1'b1;
                    c.wb_sel  = WB_ALU;
                end
            end
            OPC_OP_IMM: begin
                if (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20) begin  // Only shifts care
                    c.alu_op = base_alu[f3];
                    if (f3 == 3'd5 && f7 == 7'h20) c.alu_op = ALU_SRA;
                    c.op2_sel = OP2_I_IMM;
                    c.rf_we   = 1'b1;
                    c.wb_sel  = WB_ALU;
                end
            end
            OPC_LOAD: begin
                if (f3 != 3'd3 && f3 < 3'd6) begin  // LB LH LW LBU LHU
                    c.op2_sel    = OP2_I_IMM;
                    c.rf_we      = 1'b1;
                    c.mem_en     = 1'b1;
                    c.wb_sel     = WB_MEM;
                    c.mem_access = f3;
                end
            end
            OPC_STORE: begin
                if (f3 <= 3'd2) begin  // SB SH SW
                    c.op2_sel    = OP2_S_IMM;
                    c.mem_en     = 1'b1;
                    c.mem_wen    = 1'b1;
                    c.mem_access = f3;
                end
            end
            OPC_BRANCH: begin
                if (f3[2:1] != 2'b01) begin
                    case (f3)
                        3'd0:    taken = eq;
                        3'd1:    taken = !eq;
                        3'd4:    taken = lt;
                        3'd5:    taken = !lt;
                        3'd6:    taken = ltu;
                        default: taken = !ltu;
                    endcase
                    c.op2_sel = OP2_RS2;
                    c.wb_sel  = WB_ALU;
                    c.pc_sel  = taken ? PC_BRANCH : PC_SEQ;
                end
            end
            OPC_JAL: begin
                c.pc_sel = PC_JAL;
                c.rf_we  = 1'b1;
                c.wb_sel = WB_PC4;
            end
            OPC_JALR: begin
                if (f3 == 3'd0) begin
                    c.op2_sel = OP2_I_IMM;
                    c.pc_sel  = PC_JALR;
                    c.rf_we   = 1'b1;
                    c.wb_sel  = WB_PC4;
                end
            end
            OPC_AUIPC: begin
                c.op1_sel = OP1_PC;
                c.rf_we   = 1'b1;
                c.wb_sel  = WB_ALU;
            end
            default: begin
            end
        endcase
        return c;
    endfunction

    // Random word with the given opcode, funct3 and funct7
    function automatic logic [31:0] build_inst(input logic [6:0] opc, input logic [2:0] f3,
                                               input logic [6:0] f7);
        logic [31:0] w;
        w = $urandom;
        w[6:0]   = opc;
        w[14:12] = f3;
        w[31:25] = f7;
        return w;
    endfunction

    task automatic drive_inst(input logic [31:0] w, input logic [2:0] flags, input int ph);
        @(posedge clk);
        #1;
        inst                    = w;
        {br_eq, br_lt, br_ltu} = flags;
        phase                   = ph;
    endtask

    task automatic count_mismatch(input int idx, input int ph, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
        $display("ERROR %s (%s): expected %0h, actual %0h", out_name[idx], phase_name[ph],
                 exp_v, act_v);
        err_cnt[idx]++;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    always @(posedge clk) begin
        exp_ctrl  <= rst ? nop_c : decode_model(inst, br_eq, br_lt, br_ltu);
        exp_phase <= phase;
        chk_en    <= 1'b1;
    end

    a_alu_op: assert property (@(posedge clk) chk_en |-> alu_op == exp_ctrl.alu_op)
        else count_mismatch(0, $sampled(exp_phase), 32'($sampled(exp_ctrl.alu_op)),
                            32'($sampled(alu_op)));
    a_op1_sel: assert property (@(posedge clk) chk_en |-> op1_sel == exp_ctrl.op1_sel)
        else count_mismatch(1, $sampled(exp_phase), 32'($sampled(exp_ctrl.op1_sel)),
                            32'($sampled(op1_sel)));
    a_op2_sel: assert property (@(posedge clk) chk_en |-> op2_sel == exp_ctrl.op2_sel)
        else count_mismatch(2, $sampled(exp_phase), 32'($sampled(exp_ctrl.op2_sel)),
                            32'($sampled(op2_sel)));
    a_pc_sel: assert property (@(posedge clk) chk_en |-> pc_sel == exp_ctrl.pc_sel)
        else count_mismatch(3, $sampled(exp_phase), 32'($sampled(exp_ctrl.pc_sel)),
                            32'($sampled(pc_sel)));
    a_rf_we: assert property (@(posedge clk) chk_en |-> rf_we == exp_ctrl.rf_we)
        else count_mismatch(4, $sampled(exp_phase), 32'($sampled(exp_ctrl.rf_we)),
                            32'($sampled(rf_we)));
    a_mem_en: assert property (@(posedge clk) chk_en |-> mem_en == exp_ctrl.mem_en)
        else count_mismatch(5, $sampled(exp_phase), 32'($sampled(exp_ctrl.mem_en)),
                            32'($sampled(mem_en)));
    a_mem_wen: assert property (@(posedge clk) chk_en |-> mem_wen == exp_ctrl.mem_wen)
        else count_mismatch(6, $sampled(exp_phase), 32'($sampled(exp_ctrl.mem_wen)),
                            32'($sampled(mem_wen)));
    a_wb_sel: assert property (@(posedge clk) chk_en |-> wb_sel == exp_ctrl.wb_sel)
        else count_mismatch(7, $sampled(exp_phase), 32'($sampled(exp_ctrl.wb_sel)),
                            32'($sampled(wb_sel)));
    a_mem_access: assert property (@(posedge clk) chk_en |-> mem_access == exp_ctrl.mem_access)
        else count_mismatch(8, $sampled(exp_phase), 32'($sampled(exp_ctrl.mem_access)),
                            32'($sampled(mem_access)));
    a_is_ebreak: assert property (@(posedge clk) chk_en |-> is_ebreak == exp_ctrl.is_ebreak)
        else count_mismatch(9, $sampled(exp_phase), 32'($sampled(exp_ctrl.is_ebreak)),
                            32'($sampled(is_ebreak)));

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: stimulus did not finish within %0d clock cycles", timeout_cycles);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [31:0] w;
        int          total;
        string       line;
        void'($urandom(32'he6ec_a78c));
        rst    = 1'b1;
        inst   = reset_words[0];  // Live decode that reset has to mask
        br_eq  = 1'b0;
        br_lt  = 1'b0;
        br_ltu = 1'b0;
        for (int i = 1; i < 4; i++) begin
            drive_inst(reset_words[i], 3'($urandom), 0);
        end
        @(posedge clk);
        #1;
        rst  = 1'b0;
        inst = 32'h0000_0000;  // Unmatched opcode in the first cycle out of reset
        drive_inst(32'h0000_0000, 3'b000, 0);

        for (int rep = 0; rep < 4; rep++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                drive_inst(build_inst(OPC_OP, 3'(f3), funct7_base), 3'($urandom), 1);
                drive_inst(build_inst(OPC_OP, 3'(f3), funct7_alt), 3'($urandom), 1);
                drive_inst(build_inst(OPC_OP, 3'(f3), 7'($urandom)), 3'($urandom), 1);
                drive_inst(build_inst(OPC_OP_IMM, 3'(f3), funct7_base), 3'($urandom), 1);
                drive_inst(build_inst(OPC_OP_IMM, 3'(f3), funct7_alt), 3'($urandom), 1);
                drive_inst(build_inst(OPC_OP_IMM, 3'(f3), 7'($urandom)), 3'($urandom), 1);
            end
        end

        for (int rep = 0; rep < 4; rep++) begin
            for (int f3 = 0; f3 < 8; f3++) begin  // Includes the unmatched widths
                drive_inst(build_inst(OPC_LOAD, 3'(f3), 7'($urandom)), 3'($urandom), 2);
                drive_inst(build_inst(OPC_STORE, 3'(f3), 7'($urandom)), 3'($urandom), 2);
            end
        end

        for (int f3 = 0; f3 < 8; f3++) begin
            for (int fl = 0; fl < 8; fl++) begin  // All flag combinations
                drive_inst(build_inst(OPC_BRANCH, 3'(f3), 7'($urandom)), 3'(fl), 3);
            end
        end

        for (int n = 0; n < 8; n++) begin
            drive_inst(build_inst(OPC_JAL, 3'($urandom), 7'($urandom)), 3'($urandom), 4);
            drive_inst(build_inst(OPC_JALR, 3'(n), 7'($urandom)), 3'($urandom), 4);
            drive_inst(build_inst(OPC_AUIPC, 3'($urandom), 7'($urandom)), 3'($urandom), 4);
            drive_inst(build_inst(OPC_SYSTEM, 3'($urandom), 7'($urandom)), 3'($urandom), 4);
        end
        drive_inst(inst_ebreak, 3'($urandom), 4);
        for (int b = 0; b < 32; b++) begin
            drive_inst(inst_ebreak ^ (32'd1 << b), 3'($urandom), 4);  // One bit off
        end
        drive_inst(inst_ebreak, 3'($urandom), 4);

        for (int n = 0; n < 100; n++) begin
            w = $urandom;
            while (w[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH,
                                  OPC_JAL, OPC_JALR, OPC_AUIPC, OPC_SYSTEM}) begin
                w = $urandom;
            end
            drive_inst(w, 3'($urandom), 5);
        end

        repeat (2) @(posedge clk);  // Let the last word reach its check
        #1;
        total = 0;
        line  = "Error counts:";
        for (int i = 0; i < 10; i++) begin
            total += err_cnt[i];
            line = {line, $sformatf(" %s=%0d", out_name[i], err_cnt[i])};
        end
        $display("%s", line);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* vlog.f */
hdl/rv32_isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/ctrl_table.sv
hdl/branch_resolver.sv
hdl/ctrl_register.sv
hdl/decode_stage.sv
testbench/tb_decode_stage.sv

/* run_sim.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_decode_stage -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_decode_stage)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx 'All tests passed!'; then
    exit 0
fi
exit 1
